//--- Bender.yml
package:
  name: bpu

sources:
  - hdl/bpu_pkg.sv
  - hdl/branch_decoder.sv
  - hdl/branch_target_buffer.sv
  - hdl/direction_predictor.sv
  - hdl/return_stack.sv
  - hdl/target_select.sv
  - hdl/bpu_top.sv
  - target: test
    files:
      - test/bpu_checker.sv
      - test/bpu_tb.sv

//--- hdl/bpu_pkg.sv
package bpu_pkg;

    // datapath and address width
    localparam int XLEN = 32;

    // sequential fetch step
    localparam logic [XLEN-1:0] INST_STEP = 32'd4;

    // global history length, fixed for the tagged table hash
    localparam int HIST_WIDTH = 16;

    // link register, read as rs1 by a return
    localparam logic [4:0] RA_REG = 5'd1;

    // risc-v major opcodes of control transfers
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        CTRL_NONE,
        CTRL_BRANCH,
        CTRL_JAL,
        CTRL_JALR
    } ctrl_kind_e;

    // which table supplied the direction
    typedef enum logic {
        PROV_BIMODAL,
        PROV_TAGGED
    } provider_e;

    typedef struct packed {
        ctrl_kind_e      kind;
        logic            is_call;
        logic            is_ret;
        logic [XLEN-1:0] offset;
    } decode_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fetch_t;

    // one resolved control transfer from execute
    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic                  mispredicted;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       target;
        logic [HIST_WIDTH-1:0] history;
    } resolve_t;

    typedef struct packed {
        logic            is_ctrl;
        logic            taken;
        logic [XLEN-1:0] target;
    } prediction_t;

endpackage

//--- hdl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top #(
    parameter int BTB_ENTRIES     = 256,
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256,
    parameter int TAG_WIDTH       = 10,
    parameter int RAS_DEPTH       = 32
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  bpu_pkg::fetch_t                fetch_i,
    input  bpu_pkg::resolve_t              resolve_i,
    output bpu_pkg::prediction_t           pred_o,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o
);

    bpu_pkg::decode_t         fetch_dec;
    bpu_pkg::decode_t         resolve_dec;
    logic                     btb_hit;
    logic [bpu_pkg::XLEN-1:0] btb_target;
    logic                     btb_we;
    logic                     dir_taken;
    logic                     ras_valid;
    logic [bpu_pkg::XLEN-1:0] ras_top;

    // only taken control transfers earn a btb entry
    assign btb_we = resolve_i.valid && !stall_i && !flush_i && resolve_i.taken &&
                    (resolve_dec.kind != bpu_pkg::CTRL_NONE);

    branch_decoder u_fetch_dec (
        .inst_i (fetch_i.inst),
        .dec_o  (fetch_dec)
    );

    branch_decoder u_resolve_dec (
        .inst_i (resolve_i.inst),
        .dec_o  (resolve_dec)
    );

    branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
        .clk            (clk),
        .rst            (rst),
        .lookup_pc_i    (fetch_i.pc),
        .hit_o          (btb_hit),
        .target_o       (btb_target),
        .write_en_i     (btb_we),
        .write_pc_i     (resolve_i.pc),
        .write_target_i (resolve_i.target)
    );

    direction_predictor #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGGED_ENTRIES  (TAGGED_ENTRIES),
        .TAG_WIDTH       (TAG_WIDTH)
    ) u_dir (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .lookup_pc_i   (fetch_i.pc),
        .taken_o       (dir_taken),
        .resolve_i     (resolve_i),
        .resolve_dec_i (resolve_dec),
        .history_o     (history_o)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk           (clk),
        .rst           (rst),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .resolve_i     (resolve_i),
        .resolve_dec_i (resolve_dec),
        .top_valid_o   (ras_valid),
        .top_o         (ras_top)
    );

    target_select u_select (
        .flush_i      (flush_i),
        .fetch_i      (fetch_i),
        .fetch_dec_i  (fetch_dec),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .dir_taken_i  (dir_taken),
        .ras_valid_i  (ras_valid),
        .ras_top_i    (ras_top),
        .pred_o       (pred_o)
    );

endmodule

//--- hdl/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
    input  logic [bpu_pkg::XLEN-1:0] inst_i,
    output bpu_pkg::decode_t         dec_o
);

    bpu_pkg::opcode_e          opcode;
    logic [4:0]                rd;
    logic [4:0]                rs1;
    logic [bpu_pkg::XLEN-1:0]  b_imm;
    logic [bpu_pkg::XLEN-1:0]  j_imm;

    assign opcode = bpu_pkg::opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    // b-type immediate, bit 11 sits in inst[7]
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    // j-type immediate
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        dec_o.kind   = bpu_pkg::CTRL_NONE;
        dec_o.offset = '0;
        case (opcode)
            bpu_pkg::OPC_BRANCH: begin
                dec_o.kind   = bpu_pkg::CTRL_BRANCH;
                dec_o.offset = b_imm;
            end
            bpu_pkg::OPC_JAL: begin
                dec_o.kind   = bpu_pkg::CTRL_JAL;
                dec_o.offset = j_imm;
            end
            // jalr target is register based, no static offset
            bpu_pkg::OPC_JALR: dec_o.kind = bpu_pkg::CTRL_JALR;
            default: ;
        endcase
        // a link write marks a call
        dec_o.is_call = ((dec_o.kind == bpu_pkg::CTRL_JAL) ||
                         (dec_o.kind == bpu_pkg::CTRL_JALR)) && (rd != 5'd0);
        dec_o.is_ret  = (dec_o.kind == bpu_pkg::CTRL_JALR) && (rd == 5'd0) &&
                        (rs1 == bpu_pkg::RA_REG);
    end

endmodule

//--- hdl/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] lookup_pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o,
    input  logic                     write_en_i,
    input  logic [bpu_pkg::XLEN-1:0] write_pc_i,
    input  logic [bpu_pkg::XLEN-1:0] write_target_i
);

    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    // everything above index and word offset goes into the tag
    localparam int TAG_BITS = bpu_pkg::XLEN - IDX_BITS - 2;

    logic [TAG_BITS-1:0]          tag_mem    [BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0]     target_mem [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]       valid;

    logic [IDX_BITS-1:0] lk_idx;
    logic [TAG_BITS-1:0] lk_tag;
    logic [IDX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0] wr_tag;

    assign lk_idx = lookup_pc_i[IDX_BITS+1:2];
    assign lk_tag = lookup_pc_i[bpu_pkg::XLEN-1:IDX_BITS+2];
    assign wr_idx = write_pc_i[IDX_BITS+1:2];
    assign wr_tag = write_pc_i[bpu_pkg::XLEN-1:IDX_BITS+2];

    // same-cycle read for fetch
    assign hit_o    = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign target_o = target_mem[lk_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (write_en_i) begin
            valid[wr_idx] <= 1'b1;
        end
    end

    // tag and target are qualified by valid
    always_ff @(posedge clk) begin
        if (write_en_i) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= write_target_i;
        end
    end

endmodule

//--- hdl/direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGGED_ENTRIES  = 256,
    parameter int TAG_WIDTH       = 10
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall_i,
    input  logic                           flush_i,
    input  logic [bpu_pkg::XLEN-1:0]       lookup_pc_i,
    output logic                           taken_o,
    input  bpu_pkg::resolve_t              resolve_i,
    input  bpu_pkg::decode_t               resolve_dec_i,
    output logic [bpu_pkg::HIST_WIDTH-1:0] history_o
);

    localparam int BIM_BITS = $clog2(BIMODAL_ENTRIES);
    localparam int TGT_BITS = $clog2(TAGGED_ENTRIES);
    localparam int HW       = bpu_pkg::HIST_WIDTH;

    logic [1:0]                bim_ctr [BIMODAL_ENTRIES];
    logic [TAG_WIDTH-1:0]      tag_mem [TAGGED_ENTRIES];
    logic [1:0]                tag_ctr [TAGGED_ENTRIES];
    logic [TAGGED_ENTRIES-1:0] tag_valid;
    logic [HW-1:0]             ghist;

    logic [BIM_BITS-1:0]  lk_bidx;
    logic [TGT_BITS-1:0]  lk_tidx;
    logic [TAG_WIDTH-1:0] lk_tag;
    bpu_pkg::provider_e   lk_prov;
    logic [BIM_BITS-1:0]  up_bidx;
    logic [TGT_BITS-1:0]  up_tidx;
    logic [TAG_WIDTH-1:0] up_tag;
    bpu_pkg::provider_e   up_prov;
    logic                 accept;
    logic                 br_update;

    // pc bit 0 is always zero, so the bimodal index starts at bit 1
    function automatic logic [BIM_BITS-1:0] bim_index(input logic [bpu_pkg::XLEN-1:0] pc);
        return pc[BIM_BITS:1];
    endfunction

    function automatic logic [TGT_BITS-1:0] tgt_index(input logic [bpu_pkg::XLEN-1:0] pc,
                                                       input logic [HW-1:0] hist);
        return pc[TGT_BITS-1:0] ^ hist[HW-1 -: TGT_BITS];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] tgt_tag(input logic [bpu_pkg::XLEN-1:0] pc,
                                                     input logic [HW-1:0] hist);
        return pc[TGT_BITS +: TAG_WIDTH] ^ TAG_WIDTH'(hist[TGT_BITS-1:0]);
    endfunction

    // 2-bit saturating counter
    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

    // lookup path
    assign lk_bidx = bim_index(lookup_pc_i);
    assign lk_tidx = tgt_index(lookup_pc_i, ghist);
    assign lk_tag  = tgt_tag(lookup_pc_i, ghist);
    assign lk_prov = (tag_valid[lk_tidx] && (tag_mem[lk_tidx] == lk_tag)) ?
                     bpu_pkg::PROV_TAGGED : bpu_pkg::PROV_BIMODAL;
    assign taken_o = (lk_prov == bpu_pkg::PROV_TAGGED) ? tag_ctr[lk_tidx][1] :
                                                         bim_ctr[lk_bidx][1];

    // update path, hashed with the history the branch was fetched under
    assign accept    = resolve_i.valid && !stall_i && !flush_i;
    assign br_update = accept && (resolve_dec_i.kind == bpu_pkg::CTRL_BRANCH);
    assign up_bidx   = bim_index(resolve_i.pc);
    assign up_tidx   = tgt_index(resolve_i.pc, resolve_i.history);
    assign up_tag    = tgt_tag(resolve_i.pc, resolve_i.history);
    assign up_prov   = (tag_valid[up_tidx] && (tag_mem[up_tidx] == up_tag)) ?
                       bpu_pkg::PROV_TAGGED : bpu_pkg::PROV_BIMODAL;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bim_ctr[i] <= 2'b01;
            end
            for (int i = 0; i < TAGGED_ENTRIES; i++) begin
                tag_mem[i] <= '0;
                tag_ctr[i] <= 2'b01;
            end
            tag_valid <= '0;
        end else if (br_update) begin
            if (up_prov == bpu_pkg::PROV_TAGGED) begin
                tag_ctr[up_tidx] <= sat_step(tag_ctr[up_tidx], resolve_i.taken);
            end else begin
                bim_ctr[up_bidx] <= sat_step(bim_ctr[up_bidx], resolve_i.taken);
                // bimodal got it wrong, claim a tagged entry for this history
                if (resolve_i.mispredicted) begin
                    tag_mem[up_tidx]   <= up_tag;
                    tag_valid[up_tidx] <= 1'b1;
                    tag_ctr[up_tidx]   <= resolve_i.taken ? 2'b11 : 2'b00;
                end
            end
        end
    end

    // global history, restored from execute on redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            ghist <= '0;
        end else if (flush_i) begin
            ghist <= resolve_i.history;
        end else if (accept) begin
            ghist <= {ghist[HW-2:0], resolve_i.taken};
        end
    end

    assign history_o = ghist;

endmodule

//--- hdl/return_stack.sv
`timescale 1ns/1ps

module return_stack #(
    parameter int RAS_DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  bpu_pkg::resolve_t        resolve_i,
    input  bpu_pkg::decode_t         resolve_dec_i,
    output logic                     top_valid_o,
    output logic [bpu_pkg::XLEN-1:0] top_o
);

    localparam int PTR_BITS = $clog2(RAS_DEPTH);

    logic [bpu_pkg::XLEN-1:0] entries [RAS_DEPTH];
    // number of live entries, 0 to RAS_DEPTH
    logic [PTR_BITS:0]        count;
    logic [PTR_BITS-1:0]      top_idx;
    logic                     accept;
    logic                     push;
    logic                     pop;

    assign accept = resolve_i.valid && !stall_i && !flush_i;
    assign push   = accept && resolve_dec_i.is_call;
    assign pop    = accept && resolve_dec_i.is_ret && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (push) begin
            // full stack wraps back to the bottom slot
            count <= (count == (PTR_BITS+1)'(RAS_DEPTH)) ? (PTR_BITS+1)'(1) : count + 1'b1;
        end else if (pop) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            if (count == (PTR_BITS+1)'(RAS_DEPTH)) begin
                entries[0] <= resolve_i.pc + bpu_pkg::INST_STEP;
            end else begin
                entries[count[PTR_BITS-1:0]] <= resolve_i.pc + bpu_pkg::INST_STEP;
            end
        end
    end

    assign top_idx     = PTR_BITS'(count - 1'b1);
    assign top_valid_o = (count != '0);
    assign top_o       = entries[top_idx];

endmodule

//--- hdl/target_select.sv
`timescale 1ns/1ps

module target_select (
    input  logic                     flush_i,
    input  bpu_pkg::fetch_t          fetch_i,
    input  bpu_pkg::decode_t         fetch_dec_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic                     dir_taken_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_top_i,
    output bpu_pkg::prediction_t     pred_o
);

    logic [bpu_pkg::XLEN-1:0] seq_pc;
    logic [bpu_pkg::XLEN-1:0] rel_pc;

    assign seq_pc = fetch_i.pc + bpu_pkg::INST_STEP;
    assign rel_pc = fetch_i.pc + fetch_dec_i.offset;

    always_comb begin
        pred_o.is_ctrl = 1'b0;
        pred_o.taken   = 1'b0;
        pred_o.target  = seq_pc;
        // a redirect overrides whatever is being fetched
        if (!flush_i) begin
            case (fetch_dec_i.kind)
                bpu_pkg::CTRL_JAL: begin
                    pred_o.is_ctrl = 1'b1;
                    pred_o.taken   = 1'b1;
                    pred_o.target  = rel_pc;
                end
                bpu_pkg::CTRL_JALR: begin
                    pred_o.is_ctrl = 1'b1;
                    if (fetch_dec_i.is_ret) begin
                        // returns always jump; fall back to btb, then pc + 4
                        pred_o.taken = 1'b1;
                        if (ras_valid_i) begin
                            pred_o.target = ras_top_i;
                        end else if (btb_hit_i) begin
                            pred_o.target = btb_target_i;
                        end
                    end else begin
                        pred_o.taken = btb_hit_i;
                        if (btb_hit_i) begin
                            pred_o.target = btb_target_i;
                        end
                    end
                end
                bpu_pkg::CTRL_BRANCH: begin
                    pred_o.is_ctrl = 1'b1;
                    pred_o.taken   = dir_taken_i;
                    if (dir_taken_i) begin
                        pred_o.target = btb_hit_i ? btb_target_i : rel_pc;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- project.f
hdl/bpu_pkg.sv
hdl/branch_decoder.sv
hdl/branch_target_buffer.sv
hdl/direction_predictor.sv
hdl/return_stack.sv
hdl/target_select.sv
hdl/bpu_top.sv
test/bpu_checker.sv
test/bpu_tb.sv

//--- test/bpu_checker.sv
`timescale 1ns/1ps

module bpu_checker (
    input logic                           clk,
    input logic                           rst,
    input logic                           flush_i,
    input bpu_pkg::resolve_t              resolve_i,
    input bpu_pkg::prediction_t           pred_i,
    input bpu_pkg::decode_t               fetch_dec_i,
    input logic [bpu_pkg::HIST_WIDTH-1:0] history_i
);

    // number of assertion failures so far
    int fail_count = 0;

    // a redirect never predicts taken
    flush_not_taken: assert property (@(posedge clk) disable iff (rst)
        flush_i |-> !pred_i.taken)
        else begin
            $error("taken prediction while flush_i is high");
            fail_count++;
        end

    // history is restored from execute on the edge after a flush
    history_restored: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> (history_i == $past(resolve_i.history)))
        else begin
            $error("history_o does not hold the flushed history");
            fail_count++;
        end

    non_ctrl_not_taken: assert property (@(posedge clk) disable iff (rst)
        (fetch_dec_i.kind == bpu_pkg::CTRL_NONE) |-> !pred_i.taken)
        else begin
            $error("non-control fetch predicted taken");
            fail_count++;
        end

endmodule

bind bpu_top bpu_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .resolve_i   (resolve_i),
    .pred_i      (pred_o),
    .fetch_dec_i (fetch_dec),
    .history_i   (history_o)
);

//--- test/bpu_stimulus.txt
# F name pc inst is_ctrl taken target  (fetch, then check the prediction)
# R valid taken mispred pc inst target history  (one resolve beat)  L name history  (flush)
# S stall  (set or clear stall_i)  H name history  (check history_o), all numbers hex
F alu_fetch 00000100 00100093 0 0 00000104
F jal_fetch 00000200 0400006f 1 1 00000240
F br_cold 00000300 00000863 1 0 00000304
R 1 1 0 00000300 00000863 00000380 0000
R 1 1 0 00000300 00000863 00000380 0001
F br_trained 00000300 00000863 1 1 00000380
H hist_after_br 0003
R 1 0 1 00000300 00000863 00000304 5a3c
L flush_tagged 5a3c
H hist_flushed 5a3c
F br_tagged 00000300 00000863 1 0 00000304
R 1 1 0 00001000 040000ef 00001040 5a3c
R 1 1 0 00002000 000280e7 00003000 b479
F ret_two 00002100 00008067 1 1 00002004
R 1 1 0 00002100 00008067 00002004 68f3
F ret_one 00002100 00008067 1 1 00001004
R 1 1 0 00002200 00008067 00001004 d1e7
F ret_empty 00002340 00008067 1 1 00002344
F jalr_cold 00003000 00030067 1 0 00003004
R 1 1 0 00003000 00030067 00005000 a3cf
F jalr_trained 00003000 00030067 1 1 00005000
H hist_pre_stall 479f
S 1
R 1 1 0 00003000 00030067 00006000 479f
F jalr_stalled 00003000 00030067 1 1 00005000
S 0
H hist_post_stall 479f
F jalr_post_stall 00003000 00030067 1 1 00005000
L flush_final 1234
H hist_final 1234
F alu_final 00000100 00100093 0 0 00000104

//--- test/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_LINES      = 500;

    logic                           clk;
    logic                           rst;
    logic                           stall_i;
    logic                           flush_i;
    bpu_pkg::fetch_t                fetch_i;
    bpu_pkg::resolve_t              resolve_i;
    bpu_pkg::prediction_t           pred_o;
    logic [bpu_pkg::HIST_WIDTH-1:0] history_o;

    int checks_run;

    bpu_top #(
        .BTB_ENTRIES     (256),
        .BIMODAL_ENTRIES (512),
        .TAGGED_ENTRIES  (256),
        .TAG_WIDTH       (10),
        .RAS_DEPTH       (32)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .stall_i   (stall_i),
        .flush_i   (flush_i),
        .fetch_i   (fetch_i),
        .resolve_i (resolve_i),
        .pred_o    (pred_o),
        .history_o (history_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_run();
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks_run++;
        if (actual !== expected) begin
            $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            stop_run();
        end
    endtask

    // one-cycle inputs drop back to idle on each falling edge
    task automatic start_cycle();
        @(negedge clk);
        if (UUT.u_checker.fail_count != 0) begin
            abort_run("a concurrent assertion in the checker failed");
        end
        flush_i   = 1'b0;
        resolve_i = '0;
    endtask

    task automatic fetch_check(input string name, input logic [31:0] pc, inst,
                               input logic [31:0] exp_ctrl, exp_taken, exp_target);
        start_cycle();
        fetch_i.pc   = pc;
        fetch_i.inst = inst;
        // sample well inside the low phase
        #(CLK_PERIOD / 4);
        compare_value({name, ".is_ctrl"}, exp_ctrl, 32'(pred_o.is_ctrl));
        compare_value({name, ".taken"}, exp_taken, 32'(pred_o.taken));
        compare_value({name, ".target"}, exp_target, pred_o.target);
    endtask

    task automatic resolve_beat(input logic [31:0] valid, taken, misp, pc, inst, target,
                                input logic [31:0] hist);
        start_cycle();
        resolve_i.valid        = valid[0];
        resolve_i.taken        = taken[0];
        resolve_i.mispredicted = misp[0];
        resolve_i.pc           = pc;
        resolve_i.inst         = inst;
        resolve_i.target       = target;
        resolve_i.history      = hist[bpu_pkg::HIST_WIDTH-1:0];
    endtask

    // fetch is left as it was and the redirect masks it
    task automatic flush_cycle(input string name, input logic [31:0] hist);
        start_cycle();
        flush_i           = 1'b1;
        resolve_i.history = hist[bpu_pkg::HIST_WIDTH-1:0];
        #(CLK_PERIOD / 4);
        compare_value({name, ".is_ctrl"}, 32'd0, 32'(pred_o.is_ctrl));
        compare_value({name, ".taken"}, 32'd0, 32'(pred_o.taken));
        compare_value({name, ".target"}, fetch_i.pc + 32'd4, pred_o.target);
    endtask

    task automatic history_check(input string name, input logic [31:0] hist);
        start_cycle();
        #(CLK_PERIOD / 4);
        compare_value({name, ".history"}, hist, 32'(history_o));
    endtask

    task automatic run_command(input string line, input int line_no);
        string       cmd;
        string       name;
        int          fields;
        logic [31:0] valid;
        logic [31:0] taken;
        logic [31:0] misp;
        logic [31:0] ctrl;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] target;
        logic [31:0] hist;
        fields = $sscanf(line, "%s", cmd);
        if (cmd == "F") begin
            fields = $sscanf(line, "%s %s %h %h %h %h %h", cmd, name, pc, inst, ctrl,
                             taken, target);
            if (fields != 7) abort_run($sformatf("malformed fetch line %0d", line_no));
            fetch_check(name, pc, inst, ctrl, taken, target);
        end else if (cmd == "R") begin
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, valid, taken, misp, pc,
                             inst, target, hist);
            if (fields != 8) abort_run($sformatf("malformed resolve line %0d", line_no));
            resolve_beat(valid, taken, misp, pc, inst, target, hist);
        end else if (cmd == "L") begin
            fields = $sscanf(line, "%s %s %h", cmd, name, hist);
            if (fields != 3) abort_run($sformatf("malformed flush line %0d", line_no));
            flush_cycle(name, hist);
        end else if (cmd == "S") begin
            fields = $sscanf(line, "%s %h", cmd, valid);
            if (fields != 2) abort_run($sformatf("malformed stall line %0d", line_no));
            start_cycle();
            stall_i = valid[0];
        end else if (cmd == "H") begin
            fields = $sscanf(line, "%s %s %h", cmd, name, hist);
            if (fields != 3) abort_run($sformatf("malformed history line %0d", line_no));
            history_check(name, hist);
        end else begin
            abort_run($sformatf("unknown command on stimulus line %0d", line_no));
        end
    endtask

    // watchdog over the whole run
    initial begin
        for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
            @(posedge clk);
        end
        abort_run("the run did not finish within the cycle limit");
    end

    initial begin
        int    fd;
        int    line_no;
        bit    done;
        string line;
        rst        = 1'b1;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        fetch_i    = '0;
        resolve_i  = '0;
        checks_run = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("test/bpu_stimulus.txt", "r");
        if (fd == 0) abort_run("cannot open the stimulus file test/bpu_stimulus.txt");
        line_no = 0;
        done    = 1'b0;
        while (!done) begin
            if (line_no >= MAX_LINES) abort_run("stimulus file is longer than the line limit");
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else begin
                line_no++;
                // skip blank lines and comments
                if (line.len() > 1 && line.getc(0) != "#") begin
                    run_command(line, line_no);
                end
            end
        end
        $fclose(fd);

        // let the assertions see the last cycle
        start_cycle();

        if (checks_run == 0) begin
            abort_run("no checks were run from the stimulus file");
        end else begin
            $display("%0d values compared", checks_run);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
